// File: cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode
  import cpu_dispatch_pkg::*;
(
  input  wire           clk,
  input  wire           ext_rst_e,
  input  wire           decode_en,
  input  wire cpu_req_t cpu_req,
  input  wire           ext_cpu_e,
  output mem_cmd_t      cmd
);

  disp_op_e          op_next;
  disp_op_e          op_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;

  // read beats write beats message
  always_comb begin
    op_next = op_none;
    if (cpu_req.read) begin
      op_next = op_read;
    end else if (cpu_req.write) begin
      op_next = op_write;
    end else if (ext_cpu_e) begin
      case (cpu_req.msg)
        msg_start: op_next = op_start;
        msg_end:   op_next = op_end;
        default:   op_next = op_none;
      endcase
    end
  end

  // op falls back to none outside the command wait
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      op_q <= op_none;
    end else if (decode_en) begin
      op_q <= op_next;
    end else begin
      op_q <= op_none;
    end
  end

  // address and data only matter with a valid op
  always_ff @(posedge clk) begin
    if (decode_en) begin
      addr_q <= cpu_req.addr;
      data_q <= cpu_req.data;
    end
  end

  assign cmd = '{op: op_q, addr: addr_q, data: data_q};

  // cpu raises one request line at a time
  a_one_rw: assert property (@(posedge clk) disable iff (ext_rst_e)
    decode_en |-> !(cpu_req.read && cpu_req.write));

endmodule

`default_nettype wire

// File: cpu_dispatch_pkg.sv
`default_nettype none

package cpu_dispatch_pkg;

  // system size
  localparam int CPU_QUANTITY = 8;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // cpu number, 0 .. CPU_QUANTITY-1
  localparam int CPU_NUM_W = 3;
  // counter must reach CPU_QUANTITY itself
  localparam int CPU_CNT_W = 4;

  // message lines from the cpu, valid with ext_cpu_e
  typedef enum logic [1:0] {
    msg_none  = 2'd0,
    msg_start = 2'd1,
    msg_end   = 2'd2
  } cpu_msg_e;

  // operation picked by the decoder
  typedef enum logic [2:0] {
    op_none  = 3'd0,
    op_read  = 3'd1,
    op_write = 3'd2,
    op_start = 3'd3,
    op_end   = 3'd4
  } disp_op_e;

  // sequencer FSM
  typedef enum logic [2:0] {
    st_reset_wait = 3'd0,
    st_cpu_loop   = 3'd1,
    st_cpu_cmd    = 3'd2,
    st_mem_work   = 3'd3,
    st_mem_finish = 3'd4,
    st_ext_bus    = 3'd5
  } ctl_state_e;

  // slot offer toward the cpus
  typedef struct packed {
    // slot goes to the inactive pool
    logic                 offer_new;
    // slot goes to active cpu num
    logic                 active;
    logic [CPU_NUM_W-1:0] num;
  } cpu_index_t;

  // request from the selected cpu
  typedef struct packed {
    logic              read;
    logic              write;
    cpu_msg_e          msg;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cpu_req_t;

  // decoded command, held by the decoder
  typedef struct packed {
    disp_op_e          op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_cmd_t;

  // end of one memory operation, single cycle
  typedef struct packed {
    logic              done;
    logic              read_done;
    logic              write_done;
    // rw_halt_in ended it
    logic              halted_by_cpu;
    // ext_rw_halt_in ended it
    logic              halted_by_ext;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_end_t;

endpackage

`default_nettype wire

// File: cpu_dispatcher.f
cpu_dispatch_pkg.sv
dispatch_sequencer.sv
cmd_decode.sv
mem_access.sv
cpu_reply.sv
cpu_dispatcher.sv
tb_cpu_dispatcher.sv

// File: cpu_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_dispatcher
  import cpu_dispatch_pkg::*;
(
  input  wire               clk,
  input  wire               ext_rst_e,

  // cpu side
  input  wire cpu_req_t     cpu_req,
  input  wire               ext_cpu_e,
  input  wire               rw_halt_in,
  output logic              ext_cpu_q,
  output cpu_index_t        ext_cpu_index,
  output logic              read_dn,
  output logic              write_dn,
  output logic [DATA_W-1:0] data_out,
  output logic [ADDR_W-1:0] addr_out,
  output logic              rw_halt_out,

  // memory side
  input  wire               ext_rw_halt_in,
  input  wire               ext_read_dn,
  input  wire               ext_write_dn,
  input  wire  [ADDR_W-1:0] ext_mem_addr_in,
  input  wire  [DATA_W-1:0] ext_mem_data_in,
  output logic              ext_rw_halt_out,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic [ADDR_W-1:0] ext_mem_addr_out,
  output logic [DATA_W-1:0] ext_mem_data_out,

  // external bus master
  input  wire               ext_bus_q,
  output logic              ext_bus_allow
);

  // stage to stage
  logic     decode_en;
  logic     mem_start;
  mem_cmd_t cmd;
  mem_end_t mem_end;

  // slot loop, counters, bus grant
  dispatch_sequencer u_seq (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .ext_cpu_e     (ext_cpu_e),
    .ext_bus_q     (ext_bus_q),
    .cmd           (cmd),
    .mem_end       (mem_end),
    .ext_cpu_q     (ext_cpu_q),
    .ext_cpu_index (ext_cpu_index),
    .ext_bus_allow (ext_bus_allow),
    .decode_en     (decode_en),
    .mem_start     (mem_start)
  );

  // command register
  cmd_decode u_dec (
    .clk       (clk),
    .ext_rst_e (ext_rst_e),
    .decode_en (decode_en),
    .cpu_req   (cpu_req),
    .ext_cpu_e (ext_cpu_e),
    .cmd       (cmd)
  );

  // execute
  mem_access u_mem (
    .clk              (clk),
    .ext_rst_e        (ext_rst_e),
    .mem_start        (mem_start),
    .cmd              (cmd),
    .rw_halt_in       (rw_halt_in),
    .ext_rw_halt_in   (ext_rw_halt_in),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .mem_end          (mem_end)
  );

  // result back to the cpu
  cpu_reply u_reply (
    .clk             (clk),
    .ext_rst_e       (ext_rst_e),
    .mem_end         (mem_end),
    .read_dn         (read_dn),
    .write_dn        (write_dn),
    .data_out        (data_out),
    .addr_out        (addr_out),
    .rw_halt_out     (rw_halt_out),
    .ext_rw_halt_out (ext_rw_halt_out)
  );

endmodule

`default_nettype wire

// File: cpu_reply.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_reply
  import cpu_dispatch_pkg::*;
(
  input  wire               clk,
  input  wire               ext_rst_e,
  input  wire mem_end_t     mem_end,
  output logic              read_dn,
  output logic              write_dn,
  output logic [DATA_W-1:0] data_out,
  output logic [ADDR_W-1:0] addr_out,
  output logic              rw_halt_out,
  output logic              ext_rw_halt_out
);

  logic any_done;

  // real completion only, halts carry no data
  assign any_done = mem_end.read_done | mem_end.write_done;

  // mem_end is one cycle so every output here is a pulse
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      read_dn         <= 1'b0;
      write_dn        <= 1'b0;
      rw_halt_out     <= 1'b0;
      ext_rw_halt_out <= 1'b0;
      data_out        <= '0;
      addr_out        <= '0;
    end else begin
      read_dn  <= mem_end.read_done;
      write_dn <= mem_end.write_done;
      // memory halted, tell the cpu
      rw_halt_out <= mem_end.halted_by_ext;
      // cpu halted, tell the memory
      ext_rw_halt_out <= mem_end.halted_by_cpu;
      // returned word, zero between results
      data_out <= any_done ? mem_end.data : '0;
      addr_out <= any_done ? mem_end.addr : '0;
    end
  end

endmodule

`default_nettype wire

// File: dispatch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_sequencer
  import cpu_dispatch_pkg::*;
(
  input  wire           clk,
  input  wire           ext_rst_e,
  input  wire           ext_cpu_e,
  input  wire           ext_bus_q,
  input  wire mem_cmd_t cmd,
  input  wire mem_end_t mem_end,
  output logic          ext_cpu_q,
  output cpu_index_t    ext_cpu_index,
  output logic          ext_bus_allow,
  output logic          decode_en,
  output logic          mem_start
);

  ctl_state_e           state;
  logic [CPU_CNT_W-1:0] cnt_active;
  logic [CPU_CNT_W-1:0] cnt_inactive;
  // round-robin pointer among active cpus
  logic [CPU_NUM_W-1:0] cpu_num;
  logic [CPU_NUM_W-1:0] cpu_num_inc;
  // last slot was an offer to the pool
  logic                 new_cpu_restarted;
  logic                 rr_wrap;
  logic                 rw_op;

  assign cpu_num_inc = cpu_num + 1'b1;
  // wrap once pointer reaches active-1, also covers zero active
  assign rr_wrap = (CPU_CNT_W'(cpu_num) + 1'b1) >= cnt_active;
  assign rw_op = (cmd.op == op_read) || (cmd.op == op_write);

  // decoder samples the cpu for the whole command wait
  assign decode_en = (state == st_cpu_cmd);
  // single cycle, state leaves st_cpu_cmd right after
  assign mem_start = decode_en && rw_op;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state             <= st_reset_wait;
      cnt_active        <= '0;
      cnt_inactive      <= CPU_CNT_W'(CPU_QUANTITY);
      cpu_num           <= '0;
      new_cpu_restarted <= 1'b0;
      ext_cpu_q         <= 1'b0;
      ext_cpu_index     <= '0;
      ext_bus_allow     <= 1'b0;
    end else begin
      // slot request is a pulse
      ext_cpu_q <= 1'b0;
      case (state)
        st_reset_wait: begin
          ext_bus_allow <= 1'b0;
          state         <= st_cpu_loop;
        end

        st_cpu_loop: begin
          // bus master first
          if (ext_bus_q) begin
            state <= st_ext_bus;
          end else if (!ext_cpu_e) begin
            if (cnt_inactive != '0 && !new_cpu_restarted) begin
              ext_cpu_index     <= '{offer_new: 1'b1, active: 1'b0, num: '0};
              new_cpu_restarted <= 1'b1;
            end else begin
              if (rr_wrap) begin
                cpu_num       <= '0;
                ext_cpu_index <= '{offer_new: 1'b0, active: 1'b1, num: '0};
              end else begin
                cpu_num       <= cpu_num_inc;
                ext_cpu_index <= '{offer_new: 1'b0, active: 1'b1, num: cpu_num_inc};
              end
              new_cpu_restarted <= 1'b0;
            end
            ext_cpu_q <= 1'b1;
            state     <= st_cpu_cmd;
          end
        end

        st_cpu_cmd: begin
          // op_none keeps waiting on the cpu
          case (cmd.op)
            op_read, op_write: state <= st_mem_work;
            op_start: begin
              if (cnt_inactive != '0) begin
                cnt_inactive <= cnt_inactive - 1'b1;
                cnt_active   <= cnt_active + 1'b1;
              end
              cpu_num           <= cpu_num_inc;
              new_cpu_restarted <= 1'b0;
              state             <= st_cpu_loop;
            end
            op_end: begin
              if (cnt_active != '0) begin
                cnt_active   <= cnt_active - 1'b1;
                cnt_inactive <= cnt_inactive + 1'b1;
              end
              state <= st_cpu_loop;
            end
            default: state <= st_cpu_cmd;
          endcase
        end

        st_mem_work: begin
          // done also flags halts
          if (mem_end.done) begin
            state <= st_mem_finish;
          end
        end

        st_mem_finish: state <= st_cpu_loop;

        st_ext_bus: begin
          if (ext_bus_q) begin
            ext_bus_allow <= 1'b1;
          end else begin
            ext_bus_allow <= 1'b0;
            state         <= st_cpu_loop;
          end
        end

        default: state <= st_cpu_loop;
      endcase
    end
  end

  // one slot request per loop pass
  a_cpu_q_pulse: assert property (@(posedge clk) disable iff (ext_rst_e)
    ext_cpu_q |=> !ext_cpu_q);

  // cpus only move between the two pools
  a_cnt_sum: assert property (@(posedge clk) disable iff (ext_rst_e)
    (cnt_active + cnt_inactive) == CPU_QUANTITY);

endmodule

`default_nettype wire

// File: mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access
  import cpu_dispatch_pkg::*;
(
  input  wire               clk,
  input  wire               ext_rst_e,
  input  wire               mem_start,
  input  wire mem_cmd_t     cmd,
  input  wire               rw_halt_in,
  input  wire               ext_rw_halt_in,
  input  wire               ext_read_dn,
  input  wire               ext_write_dn,
  input  wire  [ADDR_W-1:0] ext_mem_addr_in,
  input  wire  [DATA_W-1:0] ext_mem_data_in,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic [ADDR_W-1:0] ext_mem_addr_out,
  output logic [DATA_W-1:0] ext_mem_data_out,
  output mem_end_t          mem_end
);

  logic              rd_q;
  logic              wr_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;
  logic              req_open;
  logic              halt_cpu;
  logic              halt_ext;
  logic              rd_ok;
  logic              wr_ok;
  logic              finish;

  assign req_open = rd_q | wr_q;

  // halts only count while a request is open
  // cpu side halt wins over memory side
  assign halt_cpu = req_open & rw_halt_in;
  assign halt_ext = req_open & ext_rw_halt_in & ~rw_halt_in;

  // a halt in the answer cycle drops the answer
  assign rd_ok  = rd_q & ext_read_dn & ~rw_halt_in & ~ext_rw_halt_in;
  assign wr_ok  = wr_q & ext_write_dn & ~rw_halt_in & ~ext_rw_halt_in;
  assign finish = halt_cpu | halt_ext | rd_ok | wr_ok;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
    end else if (mem_start) begin
      rd_q <= (cmd.op == op_read);
      wr_q <= (cmd.op == op_write);
    end else if (finish) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (mem_start) begin
      addr_q <= cmd.addr;
      data_q <= cmd.data;
    end
  end

  assign ext_read_q  = rd_q;
  assign ext_write_q = wr_q;
  // bus reads zero while idle
  assign ext_mem_addr_out = req_open ? addr_q : '0;
  // write data only on writes
  assign ext_mem_data_out = wr_q ? data_q : '0;

  // one cycle, the request closes on the same edge
  assign mem_end = '{
    done:          finish,
    read_done:     rd_ok,
    write_done:    wr_ok,
    halted_by_cpu: halt_cpu,
    halted_by_ext: halt_ext,
    addr:          ext_mem_addr_in,
    data:          ext_mem_data_in
  };

  a_rw_excl: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(ext_read_q && ext_write_q));

  // sequencer never starts over an open request
  a_start_idle: assert property (@(posedge clk) disable iff (ext_rst_e)
    mem_start |-> !req_open);

endmodule

`default_nettype wire

// File: tb_cpu_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_dispatcher
  import cpu_dispatch_pkg::*;
();

  localparam int NUM_SLOTS = 300;

  logic              clk;
  logic              ext_rst_e;
  cpu_req_t          cpu_req;
  logic              ext_cpu_e;
  logic              rw_halt_in;
  logic              ext_rw_halt_in;
  logic              ext_bus_q;
  logic              ext_read_dn;
  logic              ext_write_dn;
  logic [ADDR_W-1:0] ext_mem_addr_in;
  logic [DATA_W-1:0] ext_mem_data_in;
  logic              ext_cpu_q;
  cpu_index_t        ext_cpu_index;
  logic              read_dn;
  logic              write_dn;
  logic [DATA_W-1:0] data_out;
  logic [ADDR_W-1:0] addr_out;
  logic              rw_halt_out;
  logic              ext_rw_halt_out;
  logic              ext_read_q;
  logic              ext_write_q;
  logic [ADDR_W-1:0] ext_mem_addr_out;
  logic [DATA_W-1:0] ext_mem_data_out;
  logic              ext_bus_allow;

  int   seed;
  int   err_cnt;
  int   tmo_cnt;
  // reference model of the slot loop
  int   m_active;
  int   m_inactive;
  int   m_num;
  logic m_restarted;

  cpu_dispatcher dut0 (
    .clk              (clk),
    .ext_rst_e        (ext_rst_e),
    .cpu_req          (cpu_req),
    .ext_cpu_e        (ext_cpu_e),
    .rw_halt_in       (rw_halt_in),
    .ext_cpu_q        (ext_cpu_q),
    .ext_cpu_index    (ext_cpu_index),
    .read_dn          (read_dn),
    .write_dn         (write_dn),
    .data_out         (data_out),
    .addr_out         (addr_out),
    .rw_halt_out      (rw_halt_out),
    .ext_rw_halt_in   (ext_rw_halt_in),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .ext_rw_halt_out  (ext_rw_halt_out),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .ext_bus_q        (ext_bus_q),
    .ext_bus_allow    (ext_bus_allow)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // sample point, also where inputs change
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                          input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // every control output low
  task automatic check_quiet(input string what);
    check_eq({ext_cpu_q, ext_read_q, ext_write_q, read_dn, write_dn,
              rw_halt_out, ext_rw_halt_out, ext_bus_allow}, '0, what);
  endtask

  // offer_new when the pool has cpus and the last slot was no offer,
  // otherwise next active cpu, wrapping after active-1
  task automatic predict_slot(output cpu_index_t idx);
    idx = '0;
    if (m_inactive > 0 && !m_restarted) begin
      idx.offer_new = 1'b1;
      m_restarted   = 1'b1;
    end else begin
      if (m_num + 1 >= m_active) begin
        m_num = 0;
      end else begin
        m_num = m_num + 1;
      end
      idx.active  = 1'b1;
      idx.num     = CPU_NUM_W'(m_num);
      m_restarted = 1'b0;
    end
  endtask

  task automatic wait_slot();
    int n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < 40 && !seen; n++) begin
      next_cycle();
      check_eq({ext_read_q, ext_write_q}, '0, "memory request outside a command");
      seen = ext_cpu_q;
    end
    if (!seen) begin
      tmo_cnt++;
      $display("timeout: the dispatcher never offered a CPU slot");
    end
  endtask

  // start or end message, one cycle of ext_cpu_e
  task automatic do_msg(input logic is_start);
    cpu_req.msg = is_start ? msg_start : msg_end;
    ext_cpu_e   = 1'b1;
    next_cycle();
    ext_cpu_e   = 1'b0;
    cpu_req.msg = msg_none;
    check_eq(ext_cpu_q, 1'b0, "slot request while a message is served");
    if (is_start) begin
      m_inactive  = m_inactive - 1;
      m_active    = m_active + 1;
      m_num       = (m_num + 1) % CPU_QUANTITY;
      m_restarted = 1'b0;
    end else begin
      m_active   = m_active - 1;
      m_inactive = m_inactive + 1;
    end
  endtask

  task automatic do_rw(input logic is_write);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    int   lat;
    int   act;
    int   n;
    logic seen;
    addr  = $random(seed);
    wdata = $random(seed);
    rdata = $random(seed);
    cpu_req.read  = !is_write;
    cpu_req.write = is_write;
    cpu_req.addr  = addr;
    cpu_req.data  = wdata;
    seen = 1'b0;
    for (n = 0; n < 10 && !seen; n++) begin
      next_cycle();
      seen = ext_read_q | ext_write_q;
    end
    // cpu is served once the memory request opens
    cpu_req = '0;
    if (!seen) begin
      tmo_cnt++;
      $display("timeout: the CPU command never reached the memory port");
      return;
    end
    check_eq({ext_read_q, ext_write_q}, {!is_write, is_write}, "request kind");
    check_eq(ext_mem_addr_out, addr, "forwarded address");
    if (is_write) begin
      check_eq(ext_mem_data_out, wdata, "forwarded write data");
    end
    // memory latency 1 to 5 cycles, request held meanwhile
    lat = 1 + rand_below(5);
    repeat (lat - 1) begin
      next_cycle();
      check_eq({ext_read_q, ext_write_q}, {!is_write, is_write}, "request held open");
      check_eq({read_dn, write_dn, rw_halt_out, ext_rw_halt_out}, '0, "early result");
    end
    // 0..6 answer, 7..8 cpu halt, 9 memory halt
    act = rand_below(10);
    // memory bus carries a word in every case, only an answer makes it valid
    ext_mem_addr_in = addr;
    ext_mem_data_in = rdata;
    if (act < 7) begin
      ext_read_dn  = !is_write;
      ext_write_dn = is_write;
    end else if (act < 9) begin
      rw_halt_in = 1'b1;
    end else begin
      ext_rw_halt_in = 1'b1;
    end
    next_cycle();
    ext_read_dn     = 1'b0;
    ext_write_dn    = 1'b0;
    rw_halt_in      = 1'b0;
    ext_rw_halt_in  = 1'b0;
    // idle bus keeps stale words
    ext_mem_addr_in = $random(seed);
    ext_mem_data_in = $random(seed);
    check_eq({ext_read_q, ext_write_q}, '0, "request closed");
    check_eq(ext_mem_addr_out, '0, "idle memory address");
    check_eq({read_dn, write_dn}, (act < 7) ? {!is_write, is_write} : 2'b00, "done pulse");
    check_eq(ext_rw_halt_out, (act == 7 || act == 8), "halt toward memory");
    check_eq(rw_halt_out, (act == 9), "halt toward cpu");
    if (act < 7) begin
      check_eq(data_out, rdata, "returned data");
      check_eq(addr_out, addr, "returned address");
    end else begin
      check_eq({data_out, addr_out}, '0, "no result on a halt");
    end
    next_cycle();
    check_quiet("result is a single pulse");
    check_eq({data_out, addr_out}, '0, "result cleared");
  endtask

  task automatic bus_grant_test();
    int   n;
    int   hold;
    logic seen;
    check_eq(ext_bus_allow, 1'b0, "bus granted before any request");
    ext_bus_q = 1'b1;
    seen = 1'b0;
    for (n = 0; n < 10 && !seen; n++) begin
      next_cycle();
      check_eq(ext_cpu_q, 1'b0, "slot request while the bus is requested");
      seen = ext_bus_allow;
    end
    if (!seen) begin
      ext_bus_q = 1'b0;
      tmo_cnt++;
      $display("timeout: the external bus master was never granted the bus");
      return;
    end
    hold = 1 + rand_below(4);
    repeat (hold) begin
      next_cycle();
      check_eq({ext_bus_allow, ext_cpu_q}, 2'b10, "bus held by master");
    end
    ext_bus_q = 1'b0;
    next_cycle();
    // grant drops one cycle after the request
    check_eq(ext_bus_allow, 1'b0, "bus released");
  endtask

  task automatic serve_slot();
    cpu_index_t exp_idx;
    int pick;
    predict_slot(exp_idx);
    check_eq(ext_cpu_index, exp_idx, "slot offer");
    // cpu takes its time to command
    repeat (rand_below(3)) next_cycle();
    pick = rand_below(8);
    if (exp_idx.offer_new && m_inactive > 0 && pick < 4) begin
      do_msg(1'b1);
    end else if (exp_idx.active && m_active > 0 && pick == 7) begin
      do_msg(1'b0);
    end else begin
      do_rw(pick % 2 == 1);
    end
    if (tmo_cnt == 0 && rand_below(10) == 0) begin
      bus_grant_test();
    end
  endtask

  initial begin
    int n;
    seed            = 46623;
    err_cnt         = 0;
    tmo_cnt         = 0;
    ext_rst_e       = 1'b1;
    cpu_req         = '0;
    ext_cpu_e       = 1'b0;
    rw_halt_in      = 1'b0;
    ext_rw_halt_in  = 1'b0;
    ext_bus_q       = 1'b0;
    ext_read_dn     = 1'b0;
    ext_write_dn    = 1'b0;
    ext_mem_addr_in = '0;
    ext_mem_data_in = '0;
    m_active        = 0;
    m_inactive      = CPU_QUANTITY;
    m_num           = 0;
    m_restarted     = 1'b0;
    repeat (16) begin
      next_cycle();
      check_quiet("control output during reset");
    end
    check_eq(ext_cpu_index, '0, "slot offer in reset");
    ext_rst_e = 1'b0;
    // reset wait cycle
    next_cycle();
    check_quiet("control output after reset");
    for (n = 0; n < NUM_SLOTS && tmo_cnt == 0; n++) begin
      wait_slot();
      if (tmo_cnt == 0) begin
        serve_slot();
      end
    end
    $display("error counts: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
